// ==== hw/doom_update_pkg.sv ====
`default_nettype none

package doom_update_pkg;

  // frame geometry, reduced test frame
  localparam int screen_width  = 32;                          // pixels per row
  localparam int screen_height = 8;                           // rows per frame
  localparam int screen_size   = screen_width * screen_height; // pixels per frame

  // vga pixel window layout
  localparam logic [31:0] vga_px_base = 32'h0800_0000;       // window base
  localparam int          vga_x_shift = 1;                   // x field position
  localparam int          vga_y_shift = 10;                  // y field position

  // pixel buffer sizing
  localparam int fifo_depth  = 8;                             // entries == reader credits
  localparam int fifo_ptr_w  = $clog2(fifo_depth);            // ring pointer width
  localparam int credit_w    = $clog2(fifo_depth + 1);        // holds 0..fifo_depth
  localparam int count_w     = $clog2(screen_size);           // pixel counter width

  typedef logic [$clog2(screen_width)-1:0]  pixel_x_t;        // column
  typedef logic [$clog2(screen_height)-1:0] pixel_y_t;        // row
  typedef logic [7:0]                       colour_idx_t;     // palette index

  typedef struct packed {
    logic [4:0] r;                                            // red, top 5 bits
    logic [5:0] g;                                            // green, top 6 bits
    logic [4:0] b;                                            // blue, top 5 bits
  } rgb565_t;

  typedef struct packed {
    pixel_x_t    x;                                           // column tag
    pixel_y_t    y;                                           // row tag
    colour_idx_t idx;                                         // byte from screen memory
  } pixel_t;

  // screen reader FSM
  typedef enum logic [1:0] {
    st_idle,                                                  // waiting for start
    st_read_mem,                                              // mem_read held
    st_wait_credit,                                           // byte held, send when credit
    st_done                                                   // all pixels sent
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== hw/pixel_link_if.sv ====
`default_nettype none

// one-directional pixel link, flow controlled by credits
// sender starts with one credit per free receiver slot,
// receiver pulses credit once per slot it frees
interface pixel_link_if;
  import doom_update_pkg::*;

  logic   valid;                                              // one cycle per item
  pixel_t pixel;                                              // coords + index
  logic   credit;                                             // one slot freed

  // producer side
  modport sender (
    output valid,
    output pixel,
    input  credit
  );

  // consumer side, never drops an item
  modport receiver (
    input  valid,
    input  pixel,
    output credit
  );

endinterface

`default_nettype wire

// ==== hw/screen_reader.sv ====
`default_nettype none

module screen_reader (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,                  // ignored while processing
  input  logic                        done,                   // frame finished, from writer
  input  logic [31:0]                 frame_base,             // first byte of the frame
  output logic [31:0]                 mem_address,
  output logic                        mem_read,
  input  logic                        mem_waitrequest,
  input  doom_update_pkg::colour_idx_t mem_readdata,
  output logic                        fetch_done,             // level, last pixel sent
  output logic                        processing,
  pixel_link_if.sender                link
);
  import doom_update_pkg::*;

  fetch_state_t          state;
  logic [31:0]           base_q;                              // frame_base latched at start
  logic [count_w-1:0]    count;                               // linear pixel index
  pixel_x_t              x;
  pixel_y_t              y;
  colour_idx_t           data_q;                              // byte waiting to be sent
  logic [credit_w-1:0]   credits;                             // free fifo slots
  logic                  accept;                              // read done this cycle
  logic                  send;
  logic                  last_px;

  assign accept  = (state == st_read_mem) && !mem_waitrequest;
  assign send    = (state == st_wait_credit) && (credits != '0);
  assign last_px = (count == count_w'(screen_size - 1));

  assign mem_read    = (state == st_read_mem);                // held through waitrequest
  assign mem_address = base_q + 32'(count);

  assign link.valid     = send;
  assign link.pixel.x   = x;                                  // tag with coords
  assign link.pixel.y   = y;
  assign link.pixel.idx = data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      base_q     <= '0;
      count      <= '0;
      x          <= '0;
      y          <= '0;
      processing <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start && !processing) begin
            state      <= st_read_mem;                        // read issued next cycle
            base_q     <= frame_base;
            count      <= '0;
            x          <= '0;
            y          <= '0;
            processing <= 1'b1;
            fetch_done <= 1'b0;
          end
        end
        st_read_mem: begin
          if (accept) state <= st_wait_credit;               // try send next cycle
        end
        st_wait_credit: begin
          if (send) begin
            if (last_px) begin
              state      <= st_done;
              fetch_done <= 1'b1;
            end else begin
              state <= st_read_mem;
              count <= count + 1'b1;
              if (x == pixel_x_t'(screen_width - 1)) begin   // wrap to next row
                x <= '0;
                y <= y + 1'b1;
              end else begin
                x <= x + 1'b1;
              end
            end
          end
        end
        st_done: begin
          if (done) begin                                     // writer drained the frame
            state      <= st_idle;
            processing <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) data_q <= mem_readdata;                       // capture on acceptance
  end

  // credits, spent on send and returned by fifo pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_w'(fifo_depth);
    end else if (send && !link.credit) begin
      credits <= credits - 1'b1;
    end else if (!send && link.credit) begin
      credits <= credits + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo (
  input  logic           clk,
  input  logic           reset,
  pixel_link_if.receiver in_link,                             // from screen reader
  pixel_link_if.sender   out_link                             // to vga writer
);
  import doom_update_pkg::*;

  localparam int draw_credits = 1;                            // writer holds a single pixel

  pixel_t                buffer [fifo_depth];                 // ring storage
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [credit_w-1:0]   fill;                                // entries held
  logic [$clog2(draw_credits + 1)-1:0] down_credits;          // free writer slots
  logic                  push;
  logic                  pop;

  assign push = in_link.valid;                                // sender only sends with credit
  assign pop  = (fill != '0) && (down_credits != '0);

  assign out_link.valid = pop;
  assign out_link.pixel = buffer[rd_ptr];                     // head of queue
  assign in_link.credit = pop;                                // slot freed as entry leaves

  always_ff @(posedge clk) begin
    if (push) buffer[wr_ptr] <= in_link.pixel;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;                      // depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill <= '0;
    end else begin
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;                                // both or neither
      endcase
    end
  end

  // downstream credit, spent on pop and returned by writer
  always_ff @(posedge clk) begin
    if (reset) begin
      down_credits <= ($clog2(draw_credits + 1))'(draw_credits);
    end else if (pop && !out_link.credit) begin
      down_credits <= down_credits - 1'b1;
    end else if (!pop && out_link.credit) begin
      down_credits <= down_credits + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vga_pixel_writer.sv ====
`default_nettype none

module vga_pixel_writer (
  input  logic                         clk,
  input  logic                         reset,
  pixel_link_if.receiver               link,                  // from pixel fifo
  input  logic                         palette_write,
  input  doom_update_pkg::colour_idx_t palette_index,
  input  logic [23:0]                  palette_rgb,           // {r, g, b} 8 bits each
  input  logic                         fetch_done,            // reader sent every pixel
  output logic [31:0]                  vga_address,
  output logic                         vga_write,
  input  logic                         vga_waitrequest,
  output doom_update_pkg::rgb565_t     vga_writedata,
  output logic                         done
);
  import doom_update_pkg::*;

  typedef enum logic [1:0] {
    wr_idle,                                                  // waiting for a pixel
    wr_lookup,                                                // palette read
    wr_write                                                  // vga write held
  } write_state_t;

  write_state_t state;
  logic [23:0]  palette [256];                                // 24-bit colour table
  pixel_t       pix_q;                                        // captured pixel
  logic [23:0]  entry_q;                                      // palette output
  logic         accept;                                       // write taken this cycle
  logic         last_px;

  assign accept  = (state == wr_write) && !vga_waitrequest;
  assign last_px = (pix_q.x == pixel_x_t'(screen_width - 1)) &&
                   (pix_q.y == pixel_y_t'(screen_height - 1));

  assign link.credit = accept;                                // slot free again

  // palette loaded only through its port
  always_ff @(posedge clk) begin
    if (palette_write) palette[palette_index] <= palette_rgb;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wr_idle;
    end else begin
      case (state)
        wr_idle:   if (link.valid) state <= wr_lookup;
        wr_lookup: state <= wr_write;                         // vga_write rises next
        wr_write:  if (accept) state <= wr_idle;
        default:   state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == wr_idle && link.valid) pix_q <= link.pixel;  // only one in flight
    if (state == wr_lookup) entry_q <= palette[pix_q.idx];   // sync ram read
  end

  // pulse after final write of the frame
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= accept && last_px && fetch_done;
    end
  end

  assign vga_write = (state == wr_write);                     // held until accepted

  // drop low 3/2/3 bits of r/g/b
  assign vga_writedata.r = entry_q[23:19];
  assign vga_writedata.g = entry_q[15:10];
  assign vga_writedata.b = entry_q[7:3];

  assign vga_address = vga_px_base
                     | (32'(pix_q.y) << vga_y_shift)
                     | (32'(pix_q.x) << vga_x_shift);

endmodule

`default_nettype wire

// ==== hw/framebuffer_update_top.sv ====
`default_nettype none

module framebuffer_update_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic [31:0]                  frame_base,            // screen memory base
  // palette load
  input  logic                         palette_write,
  input  doom_update_pkg::colour_idx_t palette_index,
  input  logic [23:0]                  palette_rgb,
  // memory master
  output logic [31:0]                  mem_address,
  output logic                         mem_read,
  input  logic                         mem_waitrequest,
  input  doom_update_pkg::colour_idx_t mem_readdata,
  // vga master
  output logic [31:0]                  vga_address,
  output logic                         vga_write,
  input  logic                         vga_waitrequest,
  output doom_update_pkg::rgb565_t     vga_writedata,
  // status
  output logic                         processing,
  output logic                         done
);

  logic fetch_done;                                           // reader -> writer

  pixel_link_if fetch_link ();                                // reader -> fifo
  pixel_link_if draw_link ();                                 // fifo -> writer

  screen_reader u_reader (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .done            (done),                                  // feedback ends processing
    .frame_base      (frame_base),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_readdata    (mem_readdata),
    .fetch_done      (fetch_done),
    .processing      (processing),
    .link            (fetch_link.sender)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_link  (fetch_link.receiver),
    .out_link (draw_link.sender)
  );

  vga_pixel_writer u_writer (
    .clk             (clk),
    .reset           (reset),
    .link            (draw_link.receiver),
    .palette_write   (palette_write),
    .palette_index   (palette_index),
    .palette_rgb     (palette_rgb),
    .fetch_done      (fetch_done),
    .vga_address     (vga_address),
    .vga_write       (vga_write),
    .vga_waitrequest (vga_waitrequest),
    .vga_writedata   (vga_writedata),
    .done            (done)
  );

endmodule

`default_nettype wire

// ==== verif/framebuffer_update_props.sv ====
`default_nettype none

module framebuffer_update_props (
  input logic                     clk,
  input logic                     reset,
  input logic                     fetch_valid,
  input logic                     fetch_credit,
  input logic                     draw_valid,
  input logic                     draw_credit,
  input logic                     mem_read,
  input logic [31:0]              mem_address,
  input logic                     mem_waitrequest,
  input logic                     vga_write,
  input logic [31:0]              vga_address,
  input doom_update_pkg::rgb565_t vga_writedata,
  input logic                     vga_waitrequest
);
  timeunit 1ns;
  timeprecision 100ps;
  import doom_update_pkg::*;

  int   fetch_out;                                            // sent but credit not back yet
  int   draw_out;
  logic violation = 1'b0;                                     // sticky flag the testbench polls

  always @(posedge clk) begin
    if (reset) begin
      fetch_out <= 0;
      draw_out  <= 0;
    end else begin
      fetch_out <= fetch_out + int'(fetch_valid) - int'(fetch_credit);
      draw_out  <= draw_out + int'(draw_valid) - int'(draw_credit);
    end
  end

  // sender never holds more credits than its initial grant
  a_fetch_limit: assert property (@(posedge clk) disable iff (reset)
    fetch_out >= 0)
    else begin
      violation = 1'b1;
      $error("fetch link returned more credits than it granted");
    end

  a_draw_limit: assert property (@(posedge clk) disable iff (reset)
    draw_out >= 0)
    else begin
      violation = 1'b1;
      $error("draw link returned more credits than it granted");
    end

  a_fetch_credit: assert property (@(posedge clk) disable iff (reset)
    fetch_valid |-> fetch_out < fifo_depth)
    else begin
      violation = 1'b1;
      $error("fetch link valid without a credit");
    end

  a_draw_credit: assert property (@(posedge clk) disable iff (reset)
    draw_valid |-> draw_out == 0)
    else begin
      violation = 1'b1;
      $error("draw link valid without a credit");
    end

  // request held through waitrequest
  a_mem_hold: assert property (@(posedge clk) disable iff (reset)
    mem_read && mem_waitrequest |=> mem_read && $stable(mem_address))
    else begin
      violation = 1'b1;
      $error("memory read dropped or moved while stalled");
    end

  a_vga_hold: assert property (@(posedge clk) disable iff (reset)
    vga_write && vga_waitrequest |=>
      vga_write && $stable(vga_address) && $stable(vga_writedata))
    else begin
      violation = 1'b1;
      $error("vga write changed while stalled");
    end

endmodule

bind framebuffer_update_top framebuffer_update_props props_inst (
  .clk             (clk),
  .reset           (reset),
  .fetch_valid     (fetch_link.valid),
  .fetch_credit    (fetch_link.credit),
  .draw_valid      (draw_link.valid),
  .draw_credit     (draw_link.credit),
  .mem_read        (mem_read),
  .mem_address     (mem_address),
  .mem_waitrequest (mem_waitrequest),
  .vga_write       (vga_write),
  .vga_address     (vga_address),
  .vga_writedata   (vga_writedata),
  .vga_waitrequest (vga_waitrequest)
);

`default_nettype wire

// ==== verif/framebuffer_update_tb.sv ====
`default_nettype none

module framebuffer_update_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import doom_update_pkg::*;

  localparam int max_cases   = 16;
  localparam int load_cycles = 600;                           // palette load and slack per case

  logic        clk, reset, start, palette_write, mem_read, vga_write, processing, done;
  logic        mem_waitrequest = 1'b0;
  logic        vga_waitrequest = 1'b0;
  logic [31:0] frame_base, mem_address, vga_address;
  logic [23:0] palette_rgb;
  colour_idx_t palette_index, mem_readdata;
  rgb565_t     vga_writedata;

  logic [8*24-1:0] case_name [max_cases];
  logic [31:0]     case_base [max_cases];
  integer          case_seed [max_cases];
  int              case_pattern [max_cases];
  int              case_mem_pct [max_cases];
  int              case_vga_pct [max_cases];
  int              n_cases = 0;
  logic            cases_loaded = 1'b0;

  integer          stall_seed = 32'h7f53;                     // bus stall stream
  logic [23:0]     palette_model [256];                       // entries as loaded
  logic [8*24-1:0] test_name = '0;
  logic [31:0]     cur_base = '0;
  colour_idx_t     cur_pattern = '0;
  int              mem_stall = 0;
  int              vga_stall = 0;
  int              reads = 0, writes = 0, dones = 0;          // running totals
  int              reads_at = 0, writes_at = 0, dones_at = 0; // totals at case start
  logic            start_seen = 1'b0, in_frame = 1'b0;        // in_frame is start to done

  framebuffer_update_top framebuffer_update_top_inst (.*);

  assign mem_readdata = mem_address[7:0] ^ cur_pattern;       // screen memory model

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    mem_waitrequest <= ({$random(stall_seed)} % 100) < mem_stall;
    vga_waitrequest <= ({$random(stall_seed)} % 100) < vga_stall;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_address(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %0s %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  task automatic check_pixel(input string what, input rgb565_t exp, input rgb565_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %0s %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act)
      fail_run($sformatf("Mismatch %0s %s: expected %0d, actual %0d", test_name, what, exp, act));
  endtask

  // row-major position n on the vga window
  function automatic logic [31:0] expected_vga_address(input int n);
    logic [31:0] x;
    logic [31:0] y;
    x = 32'(n % screen_width);
    y = 32'(n / screen_width);
    return vga_px_base | (y << vga_y_shift) | (x << vga_x_shift);
  endfunction

  function automatic rgb565_t expected_colour(input int n);
    logic [31:0] addr;
    logic [23:0] entry;
    addr  = cur_base + 32'(n);
    entry = palette_model[addr[7:0] ^ cur_pattern];           // byte the model returns
    return {entry[23:19], entry[15:10], entry[7:3]};          // keep top 5/6/5 bits
  endfunction

  task automatic read_cases();
    int              fd;
    int              fields;
    logic [8*96-1:0] line;
    logic [8*24-1:0] name;
    logic [31:0]     base;
    integer          seed;
    int              pattern, mem_pct, vga_pct;
    fd = $fopen("verif/update_cases.txt", "r");
    if (fd == 0) fail_run("could not open verif/update_cases.txt");
    while (!$feof(fd) && n_cases < max_cases) begin
      line = '0;
      if ($fgets(line, fd) == 0) break;
      fields = $sscanf(line, "%s %h %h %h %d %d", name, base, seed, pattern, mem_pct, vga_pct);
      if (fields == 6) begin                                  // header lines fail to parse
        case_name[n_cases]    = name;
        case_base[n_cases]    = base;
        case_seed[n_cases]    = seed;
        case_pattern[n_cases] = pattern;
        case_mem_pct[n_cases] = mem_pct;
        case_vga_pct[n_cases] = vga_pct;
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  task automatic load_palette(input integer seed);
    integer s;
    s = seed;
    for (int i = 0; i < 256; i++) begin
      @(posedge clk);
      palette_model[i] = 24'($random(s));
      palette_write   <= 1'b1;
      palette_index   <= colour_idx_t'(i);
      palette_rgb     <= palette_model[i];
    end
    @(posedge clk);
    palette_write <= 1'b0;
  endtask

  task automatic run_case(input int c);
    test_name = case_name[c];
    load_palette(case_seed[c]);
    @(posedge clk);
    cur_base    = case_base[c];
    cur_pattern = colour_idx_t'(case_pattern[c]);
    mem_stall   = case_mem_pct[c];
    vga_stall   = case_vga_pct[c];
    reads_at    = reads;
    writes_at   = writes;
    dones_at    = dones;
    frame_base <= case_base[c];
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (20) @(posedge clk);
    start <= 1'b1;                                            // mid-frame start must be ignored
    @(posedge clk);
    start <= 1'b0;
    do @(posedge clk); while (!done);
    repeat (3) @(posedge clk);
    check_count("memory reads", screen_size, reads - reads_at);
    check_count("vga writes", screen_size, writes - writes_at);
    check_count("done pulses", 1, dones - dones_at);
  endtask

  // bus monitor and scoreboard
  always @(posedge clk) begin
    if (!reset) begin
      if (start_seen) check_count("mem_read after start", 1, int'(mem_read));
      check_count("processing", int'(in_frame), int'(processing));
      if (mem_read && !mem_waitrequest) begin
        if (reads - reads_at >= screen_size) fail_run("memory read past the end of the frame");
        check_address("read address", cur_base + 32'(reads - reads_at), mem_address);
        reads = reads + 1;
      end
      if (vga_write && !vga_waitrequest) begin
        if (writes - writes_at >= screen_size) fail_run("vga write past the end of the frame");
        check_address("vga address", expected_vga_address(writes - writes_at), vga_address);
        check_pixel("vga data", expected_colour(writes - writes_at), vga_writedata);
        writes = writes + 1;
      end
      if (done) begin
        check_count("writes before done", screen_size, writes - writes_at);
        dones = dones + 1;
      end
      if (framebuffer_update_top_inst.props_inst.violation)
        fail_run("a bound bus or link assertion failed");
    end
    start_seen = start && !processing && !reset;
    if (done) begin
      in_frame = 1'b0;
    end else if (start_seen) begin
      in_frame = 1'b1;
    end
  end

  initial begin
    wait (cases_loaded);
    repeat (n_cases * (screen_size * 40 + load_cycles)) @(posedge clk);
    fail_run("timeout: frame never completed");
  end

  initial begin
    reset         <= 1'b1;
    start         <= 1'b0;
    frame_base    <= '0;
    palette_write <= 1'b0;
    palette_index <= '0;
    palette_rgb   <= '0;
    read_cases();
    if (n_cases == 0) fail_run("no test cases found in verif/update_cases.txt");
    cases_loaded = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int c = 0; c < n_cases; c++) run_case(c);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== doom_update.f ====
hw/doom_update_pkg.sv
hw/pixel_link_if.sv
hw/screen_reader.sv
hw/pixel_fifo.sv
hw/vga_pixel_writer.sv
hw/framebuffer_update_top.sv
verif/framebuffer_update_props.sv
verif/framebuffer_update_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = framebuffer_update_tb
FILELIST  = doom_update.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/update_cases.txt ====
# name  frame_base  palette_seed  pattern  mem_stall_pct  vga_stall_pct
# hex: frame_base, palette_seed, pattern; decimal: stall percents
plain_frame     00001000 00000001 00 0  0
pattern_a5      00002340 00000ace a5 0  0
odd_base        00000107 0000beef 3c 10 10
vga_stall       00010000 00001234 5a 0  80
vga_stall_max   00012345 00004321 0f 0  90
mem_stall       00020000 00005a5a c3 80 0
both_stall      00030080 00007777 99 60 60
palette_swap    00001000 00009999 00 0  0
